// ==== Makefile ====
VERILATOR ?= verilator
FLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing
TOP ?= snakeGameTb
FILELIST ?= verilog.f
OBJDIR ?= obj_dir
SIM ?= snakeSim

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR) -o $(SIM)

run: build
	./$(OBJDIR)/$(SIM)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// ==== common/snakePkg.sv ====
/*
 * shared constants for the snake renderer
 * coordinate, colour and counter types, direction and draw FSM enums
 */
`default_nettype none

package snakePkg;

    // screen and block geometry
    localparam int ScreenWidth = 160;
    localparam int ScreenHeight = 120;
    localparam int BlockSize = 10;

    // snake body, one trail entry per pixel of travel
    localparam int SegmentCount = 6;
    localparam int TrailDepth = SegmentCount * BlockSize;
    // head cannot reach segment 0 or 1 by turning, so they are skipped
    localparam int HitFirstSegment = 2;
    localparam int StartHeadX = 80;
    localparam int StartHeadY = 60;

    // fixed apple
    localparam int AppleX = 30;
    localparam int AppleY = 30;

    // cycles per frame tick
    localparam int FrameTicks = 2048;

    typedef logic [$clog2(ScreenWidth)-1:0] coordXT;
    typedef logic [$clog2(ScreenHeight)-1:0] coordYT;
    typedef logic [2:0] colourT;
    typedef logic [$clog2(BlockSize)-1:0] blockOffsetT;
    typedef logic [$clog2(SegmentCount)-1:0] segmentIndexT;
    typedef logic [$clog2(FrameTicks)-1:0] frameCountT;

    // segment origins, index 0 is the head
    typedef coordXT [SegmentCount-1:0] segmentXVecT;
    typedef coordYT [SegmentCount-1:0] segmentYVecT;

    // colours as 3-bit rgb
    localparam colourT AppleColour = 3'b100;
    localparam colourT EraseColour = 3'b000;

    typedef enum logic [2:0] {none, right, down, up, left} directionT;

    typedef enum logic [2:0] {
        idle,
        drawApple,
        drawBody,
        waitTick,
        eraseBody,
        checkHit,
        moveHead,
        gameEnded
    } drawStateT;

endpackage

`default_nettype wire

// ==== test/snakeGameTb.sv ====
/*
 * testbench for the snake renderer
 * pattern-driven keys and colour, pixel stream and head position checks
 */
`timescale 1ns/1ps
`default_nettype none

module snakeGameTb;
    import snakePkg::*;

    localparam int PatternCount = 5;
    localparam int AppleCycles = BlockSize * BlockSize;
    localparam int BodyCycles = SegmentCount * BlockSize * BlockSize;

    // key nibble, colour, frames, head x, head y, game over
    logic [35:0] patterns [PatternCount];

    logic Clock;
    logic reset;
    logic start;
    logic moveRight;
    logic moveDown;
    logic moveUp;
    logic moveLeft;
    colourT snakeColour;
    coordXT pixelX;
    coordYT pixelY;
    colourT pixelColour;
    logic plot;
    logic gameOver;

    // body pixels of the last draw, replayed by the erase
    coordXT bodyX [BodyCycles];
    coordYT bodyY [BodyCycles];
    coordXT headX;
    coordYT headY;
    int cycles = 0;
    int cycleLimit = 0;
    int totalFrames;
    bit ended;

    // expected head trail, shifted once per frame
    coordXT trailX [TrailDepth];
    coordYT trailY [TrailDepth];
    directionT heading;

    snakeGame uut
    (
        .Clock(Clock),
        .reset(reset),
        .start(start),
        .moveRight(moveRight),
        .moveDown(moveDown),
        .moveUp(moveUp),
        .moveLeft(moveLeft),
        .snakeColour(snakeColour),
        .pixelX(pixelX),
        .pixelY(pixelY),
        .pixelColour(pixelColour),
        .plot(plot),
        .gameOver(gameOver)
    );

    initial
    begin
        Clock = 1'b0;
        forever #2 Clock = ~Clock;
    end

    task automatic failRun(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1);
    endtask

    // run limit, set once the pattern length is known
    always @(posedge Clock)
    begin
        cycles <= cycles + 1;
        if (cycleLimit > 0 && cycles >= cycleLimit)
            failRun("timeout: the run did not finish within its cycle limit");
    end

    task automatic checkCoordX(input string name, input coordXT expected, input coordXT actual);
        if (expected !== actual)
            failRun($sformatf("error at %0t ns: %s expected %0d, actual %0d",
                $time, name, expected, actual));
    endtask

    task automatic checkCoordY(input string name, input coordYT expected, input coordYT actual);
        if (expected !== actual)
            failRun($sformatf("error at %0t ns: %s expected %0d, actual %0d",
                $time, name, expected, actual));
    endtask

    task automatic checkColour(input string name, input colourT expected, input colourT actual);
        if (expected !== actual)
            failRun($sformatf("error at %0t ns: %s expected %0d, actual %0d",
                $time, name, expected, actual));
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (expected !== actual)
            failRun($sformatf("error at %0t ns: %s expected %0b, actual %0b",
                $time, name, expected, actual));
    endtask

    // start position, segment k repeated once per pixel of its block edge
    task automatic loadTrail();
        for (int k = 0; k < SegmentCount; k++)
        begin
            for (int r = 0; r < BlockSize; r++)
            begin
                trailX[k * BlockSize + r] = coordXT'(StartHeadX);
                trailY[k * BlockSize + r] = coordYT'(StartHeadY + BlockSize * k);
            end
        end
    endtask

    // highest pressed key wins, nothing pressed keeps the heading
    task automatic latchKeys(input logic [3:0] keys);
        if (keys[3])
            heading = right;
        else if (keys[2])
            heading = down;
        else if (keys[1])
            heading = up;
        else if (keys[0])
            heading = left;
    endtask

    // one pixel in the heading, wrapping at coordinate width
    task automatic stepTrail();
        coordXT nextX;
        coordYT nextY;
        nextX = trailX[0];
        nextY = trailY[0];
        if (heading == right)
            nextX = trailX[0] + 1'b1;
        else if (heading == left)
            nextX = trailX[0] - 1'b1;
        else if (heading == down)
            nextY = trailY[0] + 1'b1;
        else if (heading == up)
            nextY = trailY[0] - 1'b1;
        for (int i = TrailDepth - 1; i > 0; i--)
        begin
            trailX[i] = trailX[i-1];
            trailY[i] = trailY[i-1];
        end
        trailX[0] = nextX;
        trailY[0] = nextY;
    endtask

    // outputs are stable on the falling edge
    task automatic waitForPlot();
        do
            @(negedge Clock);
        while (!plot);
    endtask

    // apple first, then six blocks scanned row by row
    task automatic checkDraw(input colourT colour);
        int segPixel;
        int segment;
        coordXT expX;
        coordYT expY;
        waitForPlot();
        for (int i = 0; i < AppleCycles + BodyCycles; i++)
        begin
            if (i > 0)
                @(negedge Clock);
            checkFlag("plot", 1'b1, plot);
            if (i < AppleCycles)
            begin
                expX = coordXT'(AppleX + i % BlockSize);
                expY = coordYT'(AppleY + i / BlockSize);
                checkColour("pixelColour", AppleColour, pixelColour);
            end
            else
            begin
                segPixel = (i - AppleCycles) % AppleCycles;
                segment = (i - AppleCycles) / AppleCycles;
                // segment k sits at trail entry k times the block edge
                expX = trailX[segment * BlockSize] + coordXT'(segPixel % BlockSize);
                expY = trailY[segment * BlockSize] + coordYT'(segPixel / BlockSize);
                if (i == AppleCycles)
                begin
                    headX = pixelX;
                    headY = pixelY;
                end
                checkColour("pixelColour", colour, pixelColour);
                bodyX[i - AppleCycles] = expX;
                bodyY[i - AppleCycles] = expY;
            end
            checkCoordX("pixelX", expX, pixelX);
            checkCoordY("pixelY", expY, pixelY);
        end
        // waiting for the tick now
        @(negedge Clock);
        checkFlag("plot", 1'b0, plot);
    endtask

    // erase replays the drawn body in black, then check and move follow
    task automatic checkErase();
        waitForPlot();
        for (int i = 0; i < BodyCycles; i++)
        begin
            if (i > 0)
                @(negedge Clock);
            checkFlag("plot", 1'b1, plot);
            checkCoordX("pixelX", bodyX[i], pixelX);
            checkCoordY("pixelY", bodyY[i], pixelY);
            checkColour("pixelColour", EraseColour, pixelColour);
        end
        @(negedge Clock);
        checkFlag("plot", 1'b0, plot);
        // gameOver settles one cycle after the hit check
        @(negedge Clock);
        checkFlag("plot", 1'b0, plot);
    endtask

    initial
    begin
        reset = 1'b1;
        start = 1'b0;
        moveRight = 1'b0;
        moveDown = 1'b0;
        moveUp = 1'b0;
        moveLeft = 1'b0;
        snakeColour = 3'b010;
        ended = 1'b0;
        heading = none;
        loadTrail();
        $readmemh("test/snakePatterns.mem", patterns);
        totalFrames = 0;
        for (int p = 0; p < PatternCount; p++)
            totalFrames += int'(patterns[p][27:20]);
        // two ticks per frame and one tick of margin
        cycleLimit = 2 * totalFrames * FrameTicks + FrameTicks;

        repeat (16) @(negedge Clock);
        reset = 1'b0;

        // start held low across the first tick
        repeat (FrameTicks + 50)
        begin
            @(negedge Clock);
            checkFlag("plot", 1'b0, plot);
        end
        start = 1'b1;

        // no key yet, head at the start position
        checkDraw(snakeColour);
        checkCoordX("headX", coordXT'(StartHeadX), headX);
        checkCoordY("headY", coordYT'(StartHeadY), headY);

        for (int p = 0; p < PatternCount; p++)
        begin
            // applied while the FSM waits for the tick
            {moveRight, moveDown, moveUp, moveLeft} = patterns[p][35:32];
            snakeColour = patterns[p][30:28];
            latchKeys(patterns[p][35:32]);
            for (int f = 0; f < int'(patterns[p][27:20]); f++)
            begin
                if (!ended)
                begin
                    checkErase();
                    if (gameOver)
                        ended = 1'b1;
                    else
                    begin
                        stepTrail();
                        checkDraw(snakeColour);
                    end
                end
            end
            checkCoordX("headX", patterns[p][19:12], headX);
            checkCoordY("headY", patterns[p][10:4], headY);
            checkFlag("gameOver", patterns[p][0], gameOver);
        end

        // game ended, nothing more is drawn
        repeat (2 * FrameTicks)
        begin
            @(negedge Clock);
            checkFlag("plot", 1'b0, plot);
            checkFlag("gameOver", 1'b1, gameOver);
        end

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/snakeGame_assertions.sv ====
/*
 * concurrent checks on the snake top level, attached by bind
 */
`timescale 1ns/1ps
`default_nettype none

module snakeGameAssertions
(
    input logic Clock,
    input logic reset,
    input logic plot,
    input logic gameOver,
    input logic moveStep,
    input logic blockDone,
    input logic scanStep
);

    // nothing drawn once the game has ended
    assert property (@(posedge Clock) disable iff (reset) !(plot && gameOver))
        else $error("plot high while gameOver");

    // move happens between erase and draw
    assert property (@(posedge Clock) disable iff (reset) !(plot && moveStep))
        else $error("plot and moveStep together");

    // sticky until reset
    assert property (@(posedge Clock) disable iff (reset) gameOver |=> gameOver)
        else $error("gameOver fell without reset");

    // a scan run ends only right after the last pixel of a block
    assert property (@(posedge Clock) disable iff (reset)
        $fell(scanStep) |-> $past(blockDone))
        else $error("scan stopped before the end of a block");

endmodule

bind snakeGame snakeGameAssertions assertions
(
    .Clock(Clock),
    .reset(reset),
    .plot(plot),
    .gameOver(gameOver),
    .moveStep(moveStep),
    .blockDone(blockDone),
    .scanStep(scanStep)
);

`default_nettype wire

// ==== test/snakePatterns.mem ====
// one step per line, hex digits: K C FF XX YY G
// K keys (right down up left), C colour, FF frames, XX/YY head after, G gameOver
// no key, head stays put while the trail shifts
0202503C0
// right held
8203533C0
// keys released, right continues, new colour
0304573C0
// up and left held, up wins
3202573A0
// reverse down into the body
4202573A1

// ==== verilog.f ====
common/snakePkg.sv
verilog/frameTimer.sv
verilog/blockScanner.sv
verilog/collisionCheck.sv
verilog/snakeBoard.sv
verilog/drawSequencer.sv
verilog/snakeGame.sv
test/snakeGame_assertions.sv
test/snakeGameTb.sv

// ==== verilog/blockScanner.sv ====
/*
 * 10x10 pixel offset counters and pixel address adder
 */
`timescale 1ns/1ps
`default_nettype none

module blockScanner
(
    input logic Clock,
    input logic reset,
    input logic scanClear,
    input logic scanStep,
    input snakePkg::coordXT blockX,
    input snakePkg::coordYT blockY,
    output snakePkg::coordXT pixelX,
    output snakePkg::coordYT pixelY,
    output logic blockDone
);
    import snakePkg::*;

    blockOffsetT xOffset;
    blockOffsetT yOffset;
    logic xLast;
    logic yLast;

    assign xLast = (xOffset == blockOffsetT'(BlockSize - 1));
    assign yLast = (yOffset == blockOffsetT'(BlockSize - 1));

    // x inner, y steps on x wrap
    always_ff @(posedge Clock)
    begin
        if (reset || scanClear)
        begin
            xOffset <= '0;
            yOffset <= '0;
        end
        else if (scanStep)
        begin
            if (xLast)
            begin
                xOffset <= '0;
                yOffset <= yLast ? '0 : yOffset + 1'b1;
            end
            else
                xOffset <= xOffset + 1'b1;
        end
    end

    // last pixel of the block
    assign blockDone = scanStep && xLast && yLast;

    // wraps at coordinate width
    assign pixelX = blockX + coordXT'(xOffset);
    assign pixelY = blockY + coordYT'(yOffset);

endmodule

`default_nettype wire

// ==== verilog/collisionCheck.sv ====
/*
 * overlap test between next head block and body blocks
 */
`timescale 1ns/1ps
`default_nettype none

module collisionCheck
(
    input snakePkg::coordXT nextHeadX,
    input snakePkg::coordYT nextHeadY,
    input snakePkg::segmentXVecT segmentX,
    input snakePkg::segmentYVecT segmentY,
    output logic headHit
);
    import snakePkg::*;

    // absolute distance, no wrap handling
    function automatic int gap(input int a, input int b);
        if (a > b)
            return a - b;
        return b - a;
    endfunction

    // blocks overlap when both gaps are under one block edge
    always_comb
    begin
        headHit = 1'b0;
        for (int k = HitFirstSegment; k < SegmentCount; k++)
        begin
            if (gap(nextHeadX, segmentX[k]) < BlockSize &&
                gap(nextHeadY, segmentY[k]) < BlockSize)
                headHit = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/drawSequencer.sv ====
/*
 * draw FSM: apple and body draw, tick wait, erase, hit check, move
 * also owns the segment counter and the pixel colour
 */
`timescale 1ns/1ps
`default_nettype none

module drawSequencer
(
    input logic Clock,
    input logic reset,
    input logic start,
    input logic frameTick,
    input logic blockDone,
    input logic headHit,
    input snakePkg::colourT snakeColour,
    output logic scanClear,
    output logic scanStep,
    output logic appleSelect,
    output logic moveStep,
    output snakePkg::segmentIndexT segmentIndex,
    output logic plot,
    output snakePkg::colourT pixelColour,
    output logic gameOver
);
    import snakePkg::*;

    drawStateT state;
    drawStateT nextState;
    logic lastSegment;

    assign lastSegment = (segmentIndex == segmentIndexT'(SegmentCount - 1));

    // state transitions
    always_comb
    begin
        nextState = state;
        case (state)
            idle:
            begin
                // first frame only after start and a tick
                if (start && frameTick)
                    nextState = drawApple;
            end
            drawApple:
            begin
                if (blockDone)
                    nextState = drawBody;
            end
            drawBody:
            begin
                if (blockDone && lastSegment)
                    nextState = waitTick;
            end
            waitTick:
            begin
                if (frameTick)
                    nextState = eraseBody;
            end
            eraseBody:
            begin
                if (blockDone && lastSegment)
                    nextState = checkHit;
            end
            checkHit:
            begin
                // headHit is combinational from the board
                if (headHit)
                    nextState = gameEnded;
                else
                    nextState = moveHead;
            end
            moveHead:
                nextState = drawApple;
            default:
                nextState = gameEnded;
        endcase
    end

    // state and segment counter
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            state <= idle;
            segmentIndex <= '0;
        end
        else
        begin
            state <= nextState;
            // apple block leaves the counter at zero
            if (blockDone && (state == drawBody || state == eraseBody))
            begin
                if (lastSegment)
                    segmentIndex <= '0;
                else
                    segmentIndex <= segmentIndex + 1'b1;
            end
        end
    end

    // outputs decoded from state
    always_comb
    begin
        scanClear = 1'b1;
        scanStep = 1'b0;
        appleSelect = 1'b0;
        moveStep = 1'b0;
        plot = 1'b0;
        pixelColour = EraseColour;
        case (state)
            drawApple:
            begin
                scanClear = 1'b0;
                scanStep = 1'b1;
                appleSelect = 1'b1;
                plot = 1'b1;
                pixelColour = AppleColour;
            end
            drawBody:
            begin
                scanClear = 1'b0;
                scanStep = 1'b1;
                plot = 1'b1;
                pixelColour = snakeColour;
            end
            eraseBody:
            begin
                scanClear = 1'b0;
                scanStep = 1'b1;
                plot = 1'b1;
            end
            moveHead:
                moveStep = 1'b1;
            default:
                plot = 1'b0;
        endcase
    end

    // held until reset
    assign gameOver = (state == gameEnded);

endmodule

`default_nettype wire

// ==== verilog/frameTimer.sv ====
/*
 * free-running frame tick generator
 */
`timescale 1ns/1ps
`default_nettype none

module frameTimer
(
    input logic Clock,
    input logic reset,
    output logic frameTick
);
    import snakePkg::*;

    frameCountT count;

    // tick is registered, so first pulse lands FrameTicks cycles after reset
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            count <= '0;
            frameTick <= 1'b0;
        end
        else
        begin
            frameTick <= (count == frameCountT'(FrameTicks - 1));
            if (count == frameCountT'(FrameTicks - 1))
                count <= '0;
            else
                count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/snakeBoard.sv ====
/*
 * direction latch, head position trail, next head
 * block origin select between apple and segments
 */
`timescale 1ns/1ps
`default_nettype none

module snakeBoard
(
    input logic Clock,
    input logic reset,
    input logic moveRight,
    input logic moveDown,
    input logic moveUp,
    input logic moveLeft,
    input logic moveStep,
    input logic appleSelect,
    input snakePkg::segmentIndexT segmentIndex,
    output snakePkg::coordXT blockX,
    output snakePkg::coordYT blockY,
    output logic headHit
);
    import snakePkg::*;

    directionT direction;
    coordXT trailX [TrailDepth];
    coordYT trailY [TrailDepth];
    coordXT nextHeadX;
    coordYT nextHeadY;
    segmentXVecT segmentX;
    segmentYVecT segmentY;

    // priority right, down, up, left; holds on release
    always_ff @(posedge Clock)
    begin
        if (reset)
            direction <= none;
        else if (moveRight)
            direction <= right;
        else if (moveDown)
            direction <= down;
        else if (moveUp)
            direction <= up;
        else if (moveLeft)
            direction <= left;
    end

    // one pixel from the current head
    always_comb
    begin
        nextHeadX = trailX[0];
        nextHeadY = trailY[0];
        case (direction)
            right: nextHeadX = trailX[0] + 1'b1;
            left: nextHeadX = trailX[0] - 1'b1;
            down: nextHeadY = trailY[0] + 1'b1;
            up: nextHeadY = trailY[0] - 1'b1;
            default: nextHeadX = trailX[0];
        endcase
    end

    // vertical start, each segment repeated BlockSize times
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            for (int i = 0; i < TrailDepth; i++)
            begin
                trailX[i] <= coordXT'(StartHeadX);
                trailY[i] <= coordYT'(StartHeadY + BlockSize * (i / BlockSize));
            end
        end
        else if (moveStep)
        begin
            trailX[0] <= nextHeadX;
            trailY[0] <= nextHeadY;
            for (int i = 1; i < TrailDepth; i++)
            begin
                trailX[i] <= trailX[i-1];
                trailY[i] <= trailY[i-1];
            end
        end
    end

    // segment k sits BlockSize moves behind segment k-1
    for (genvar k = 0; k < SegmentCount; k++)
    begin : segmentTap
        assign segmentX[k] = trailX[k * BlockSize];
        assign segmentY[k] = trailY[k * BlockSize];
    end

    // origin of the block being scanned
    always_comb
    begin
        blockX = segmentX[0];
        blockY = segmentY[0];
        if (appleSelect)
        begin
            blockX = coordXT'(AppleX);
            blockY = coordYT'(AppleY);
        end
        else if (segmentIndex < SegmentCount)
        begin
            blockX = segmentX[segmentIndex];
            blockY = segmentY[segmentIndex];
        end
    end

    collisionCheck hitTest
    (
        .nextHeadX(nextHeadX),
        .nextHeadY(nextHeadY),
        .segmentX(segmentX),
        .segmentY(segmentY),
        .headHit(headHit)
    );

endmodule

`default_nettype wire

// ==== verilog/snakeGame.sv ====
/*
 * snake game top level
 * frame timer, draw FSM, block scanner and snake board
 */
`timescale 1ns/1ps
`default_nettype none

module snakeGame
(
    input logic Clock,
    input logic reset,
    input logic start,
    input logic moveRight,
    input logic moveDown,
    input logic moveUp,
    input logic moveLeft,
    input snakePkg::colourT snakeColour,
    output snakePkg::coordXT pixelX,
    output snakePkg::coordYT pixelY,
    output snakePkg::colourT pixelColour,
    output logic plot,
    output logic gameOver
);
    import snakePkg::*;

    // pacing
    logic frameTick;

    // FSM to scanner
    logic scanClear;
    logic scanStep;
    logic blockDone;

    // FSM to board
    logic appleSelect;
    logic moveStep;
    segmentIndexT segmentIndex;
    logic headHit;

    // selected block origin
    coordXT blockX;
    coordYT blockY;

    frameTimer timer
    (
        .Clock(Clock),
        .reset(reset),
        .frameTick(frameTick)
    );

    drawSequencer sequencer
    (
        .Clock(Clock),
        .reset(reset),
        .start(start),
        .frameTick(frameTick),
        .blockDone(blockDone),
        .headHit(headHit),
        .snakeColour(snakeColour),
        .scanClear(scanClear),
        .scanStep(scanStep),
        .appleSelect(appleSelect),
        .moveStep(moveStep),
        .segmentIndex(segmentIndex),
        .plot(plot),
        .pixelColour(pixelColour),
        .gameOver(gameOver)
    );

    blockScanner scanner
    (
        .Clock(Clock),
        .reset(reset),
        .scanClear(scanClear),
        .scanStep(scanStep),
        .blockX(blockX),
        .blockY(blockY),
        .pixelX(pixelX),
        .pixelY(pixelY),
        .blockDone(blockDone)
    );

    snakeBoard board
    (
        .Clock(Clock),
        .reset(reset),
        .moveRight(moveRight),
        .moveDown(moveDown),
        .moveUp(moveUp),
        .moveLeft(moveLeft),
        .moveStep(moveStep),
        .appleSelect(appleSelect),
        .segmentIndex(segmentIndex),
        .blockX(blockX),
        .blockY(blockY),
        .headHit(headHit)
    );

endmodule

`default_nettype wire
